// ==== loader_macros.svh ====
// Loader sizing constants shared by the parser, write queue and memory writer.

`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// ********************
// Program memory
// ********************

// Bytes of program RAM on the board.
`define LOAD_MEM_DEPTH 1024

// Width of a record address as carried through the queue.
// Only the low bits that index RAM are used by the writer.
`define LOAD_ADDR_W 16

// ********************
// Write queue
// ********************

// Pending writes held between parser and memory writer.
`define LOAD_FIFO_DEPTH 8

`endif

// ==== ihex_pkg.sv ====
// Intel HEX record, error and queued-write types for the program loader.

`include "loader_macros.svh"

package ihex_pkg;

	// ********************
	// Parser faults
	// ********************

	// First fault seen is kept until soft_reset.
	typedef enum logic [2:0] {
		err_none         = 3'd0,
		err_bad_start    = 3'd1,	// Junk where a colon was expected.
		err_bad_digit    = 3'd2,	// Non-hex character inside a record.
		err_bad_checksum = 3'd3,
		err_bad_type     = 3'd4,	// Record type other than 00 or 01.
		err_out_of_range = 3'd5	// Data byte above program RAM.
	} ihex_err_e;

	// ********************
	// Queue entries
	// ********************

	typedef enum logic {
		kind_data = 1'b0,
		kind_eof  = 1'b1
	} load_kind_e;

	// One pending write, or the end marker of an image.
	typedef struct packed {
		load_kind_e               kind;
		logic [`LOAD_ADDR_W-1:0]  addr;
		logic [7:0]               data;	// Zero for an end marker.
	} load_write_t;

endpackage

// ==== apb_pkg.sv ====
// APB read-back port types and the loader status word layout.

package apb_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [7:0]  pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic [7:0]  prdata;
		logic        pslverr;
	} apb_rsp_t;

	// Status word, read at the top of the APB space.
	typedef struct packed {
		logic        done;	// End record stored.
		logic        queue_empty;
		logic [2:0]  zero;
		logic [2:0]  error;	// Sticky parser fault code.
	} load_status_t;

	localparam logic [11:0] status_addr = 12'hfff;

endpackage

// ==== intel_hex_parser.sv ====
// Intel HEX parser turning ASCII record characters into queued byte writes and end markers.

`include "loader_macros.svh"

module intel_hex_parser import ihex_pkg::*; (
	input  logic        clk,
	input  logic        soft_reset,

	input  logic        i_rx_valid,
	input  logic [7:0]  i_rx_data,
	output logic        o_rx_ready,

	output logic        o_push,
	output load_write_t o_entry,
	input  logic        i_full,

	output ihex_err_e   o_error
);

	typedef enum logic [2:0] {
		st_start,
		st_len,
		st_addr_hi,
		st_addr_lo,
		st_type,
		st_data,
		st_csum
	} parse_state_e;

	parse_state_e             state_q;
	logic                     have_hi_q;	// High digit of a byte is held.
	logic [3:0]               hi_nib_q;
	logic [7:0]               remain_q;	// Data bytes left in the record.
	logic [`LOAD_ADDR_W-1:0]  addr_q;
	logic                     eof_q;
	logic [7:0]               sum_q;
	logic                     pend_q;	// Entry waiting for the queue.
	load_write_t              entry_q;
	ihex_err_e                err_q;

	logic                     accept;
	logic                     is_colon;
	logic                     is_space;
	logic                     digit_ok;
	logic [3:0]               digit;
	logic [7:0]               rx_byte;
	logic [7:0]               sum_next;

	// ********************
	// Character decode
	// ********************

	always_comb begin
		digit_ok = 1'b1;
		digit = 4'h0;
		if (i_rx_data >= "0" && i_rx_data <= "9")
			digit = i_rx_data[3:0];
		else if ((i_rx_data >= "A" && i_rx_data <= "F") ||
				(i_rx_data >= "a" && i_rx_data <= "f"))
			digit = i_rx_data[3:0] + 4'd9;	// Low nibble of 'A' is 1.
		else
			digit_ok = 1'b0;
	end

	assign is_colon = i_rx_data == ":";
	assign is_space = i_rx_data == 8'h0d || i_rx_data == 8'h0a || i_rx_data == " ";

	assign rx_byte = {hi_nib_q, digit};
	assign sum_next = sum_q + rx_byte;

	// Stall only while a finished entry cannot enter the queue.
	assign o_rx_ready = !(pend_q && i_full);
	assign accept = i_rx_valid && o_rx_ready;

	assign o_push = pend_q && !i_full;
	assign o_entry = entry_q;
	assign o_error = err_q;

	// ********************
	// Record FSM
	// ********************

	always_ff @(posedge clk) begin
		if (o_push)
			pend_q <= 1'b0;

		if (soft_reset) begin
			state_q <= st_start;
			have_hi_q <= 1'b0;
			pend_q <= 1'b0;
			err_q <= err_none;
		end
		else if (accept) begin
			if (state_q == st_start) begin
				if (is_colon) begin
					state_q <= st_len;
					sum_q <= 8'h00;
					have_hi_q <= 1'b0;
				end
				else if (!is_space && err_q == err_none)
					err_q <= err_bad_start;
			end
			else if (is_colon) begin
				// A colon inside a record restarts on the new one.
				if (err_q == err_none)
					err_q <= err_bad_digit;
				state_q <= st_len;
				sum_q <= 8'h00;
				have_hi_q <= 1'b0;
			end
			else if (!digit_ok) begin
				if (err_q == err_none)
					err_q <= err_bad_digit;
				state_q <= st_start;	// Hunt for the next colon.
			end
			else if (!have_hi_q) begin
				hi_nib_q <= digit;
				have_hi_q <= 1'b1;
			end
			else begin
				have_hi_q <= 1'b0;
				sum_q <= sum_next;
				case (state_q)
				st_len: begin
					remain_q <= rx_byte;
					state_q <= st_addr_hi;
				end

				st_addr_hi: begin
					addr_q[15:8] <= rx_byte;
					state_q <= st_addr_lo;
				end

				st_addr_lo: begin
					addr_q[7:0] <= rx_byte;
					state_q <= st_type;
				end

				st_type: begin
					eof_q <= rx_byte == 8'h01;
					if (rx_byte == 8'h00)
						state_q <= (remain_q == 8'h00) ? st_csum : st_data;
					else if (rx_byte == 8'h01)
						state_q <= st_csum;
					else begin
						if (err_q == err_none)
							err_q <= err_bad_type;
						state_q <= st_start;
					end
				end

				st_data: begin
					pend_q <= 1'b1;
					entry_q.kind <= kind_data;
					entry_q.addr <= addr_q;
					entry_q.data <= rx_byte;
					if (addr_q >= `LOAD_MEM_DEPTH && err_q == err_none)
						err_q <= err_out_of_range;	// Writer drops this byte.
					addr_q <= addr_q + 1'b1;
					remain_q <= remain_q - 1'b1;
					if (remain_q == 8'h01)
						state_q <= st_csum;
				end

				st_csum: begin
					state_q <= st_start;
					if (sum_next != 8'h00) begin
						if (err_q == err_none)
							err_q <= err_bad_checksum;
					end
					else if (eof_q && err_q == err_none) begin
						pend_q <= 1'b1;
						entry_q.kind <= kind_eof;
						entry_q.addr <= addr_q;
						entry_q.data <= 8'h00;
					end
				end

				default:
					state_q <= st_start;
				endcase
			end
		end
	end

	// ********************
	// Checks
	// ********************

	// A blocked entry is held unchanged until the queue takes it.
	a_hold_entry: assert property (@(posedge clk) disable iff (soft_reset)
		pend_q && i_full |=> pend_q && $stable(entry_q));

endmodule

// ==== load_fifo.sv ====
// Show-ahead queue of pending writes between the HEX parser and the memory writer.

`include "loader_macros.svh"

module load_fifo import ihex_pkg::*; (
	input  logic        clk,
	input  logic        soft_reset,

	input  logic        i_push,
	input  load_write_t i_entry,
	output logic        o_full,

	input  logic        i_pop,
	output load_write_t o_head,
	output logic        o_empty
);

	localparam int depth = `LOAD_FIFO_DEPTH;
	localparam int ptr_w = $clog2(depth);

	load_write_t      mem [depth];
	logic [ptr_w-1:0] wr_ptr_q;
	logic [ptr_w-1:0] rd_ptr_q;
	logic [ptr_w:0]   count_q;

	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign o_full = count_q == (ptr_w + 1)'(depth);
	assign o_empty = count_q == '0;
	assign o_head = mem[rd_ptr_q];	// Head is valid while not empty.

	always_ff @(posedge clk) begin
		if (i_push)
			mem[wr_ptr_q] <= i_entry;
	end

	always_ff @(posedge clk) begin
		if (soft_reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else begin
			if (i_push)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (i_pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			case ({i_push, i_pop})
			2'b10: count_q <= count_q + 1'b1;
			2'b01: count_q <= count_q - 1'b1;
			default: ;	// Both or neither.
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (soft_reset)
		i_push |-> !o_full);

	a_no_underflow: assert property (@(posedge clk) disable iff (soft_reset)
		i_pop |-> !o_empty);

endmodule

// ==== load_memory.sv ====
// Memory writer that drains queued writes into program RAM and serves APB read-back.

`include "loader_macros.svh"

module load_memory import ihex_pkg::*, apb_pkg::*; (
	input  logic        clk,
	input  logic        soft_reset,

	input  load_write_t i_head,
	input  logic        i_empty,
	output logic        o_pop,

	input  ihex_err_e   i_error,

	input  apb_req_t    i_apb,
	output apb_rsp_t    o_apb
);

	localparam int ram_aw = $clog2(`LOAD_MEM_DEPTH);

	logic [7:0]   ram [`LOAD_MEM_DEPTH];
	logic         done_q;
	logic [7:0]   prdata_q;

	logic         wr_ok;
	logic         setup;
	logic         access;
	logic         ram_hit;
	logic         status_hit;
	load_status_t status;

	// ********************
	// Queue drain
	// ********************

	assign o_pop = !i_empty;
	assign wr_ok = o_pop && i_head.kind == kind_data && i_head.addr < `LOAD_MEM_DEPTH;

	always_ff @(posedge clk) begin
		if (soft_reset)
			done_q <= 1'b0;
		else if (o_pop && i_head.kind == kind_eof)
			done_q <= 1'b1;	// Held until reset.
	end

	// ********************
	// APB read-back
	// ********************

	assign setup = i_apb.psel && !i_apb.penable;
	assign access = i_apb.psel && i_apb.penable;
	assign ram_hit = i_apb.paddr < `LOAD_MEM_DEPTH;
	assign status_hit = i_apb.paddr == status_addr;

	assign status = '{
		done:        done_q,
		queue_empty: i_empty,
		zero:        3'b000,
		error:       i_error
	};

	always_ff @(posedge clk) begin
		if (wr_ok)
			ram[i_head.addr[ram_aw-1:0]] <= i_head.data;

		// Read data is fetched in the setup phase.
		if (setup) begin
			if (ram_hit)
				prdata_q <= ram[i_apb.paddr[ram_aw-1:0]];
			else if (status_hit)
				prdata_q <= status;
			else
				prdata_q <= 8'h00;
		end
	end

	assign o_apb.pready = access;	// No wait states.
	assign o_apb.prdata = prdata_q;
	assign o_apb.pslverr = access && (i_apb.pwrite || !(ram_hit || status_hit));

	a_apb_phases: assert property (@(posedge clk) disable iff (soft_reset)
		i_apb.penable |-> $past(i_apb.psel));

endmodule

// ==== hex_loader_top.sv ====
// Program loader top level joining the HEX parser, write queue and memory writer.

module hex_loader_top import ihex_pkg::*, apb_pkg::*; (
	input  logic       clk,
	input  logic       soft_reset,

	input  logic       i_rx_valid,
	input  logic [7:0] i_rx_data,
	output logic       o_rx_ready,

	input  apb_req_t   i_apb,
	output apb_rsp_t   o_apb
);

	logic        push;
	logic        full;
	logic        pop;
	logic        empty;
	load_write_t entry;
	load_write_t head;
	ihex_err_e   error;

	intel_hex_parser intel_hex_parser_inst (
		.clk,
		.soft_reset,
		.i_rx_valid,
		.i_rx_data,
		.o_rx_ready,
		.o_push(push),
		.o_entry(entry),
		.i_full(full),
		.o_error(error)
	);

	load_fifo load_fifo_inst (
		.clk,
		.soft_reset,
		.i_push(push),
		.i_entry(entry),
		.o_full(full),
		.i_pop(pop),
		.o_head(head),
		.o_empty(empty)
	);

	load_memory load_memory_inst (
		.clk,
		.soft_reset,
		.i_head(head),
		.i_empty(empty),
		.o_pop(pop),
		.i_error(error),
		.i_apb,
		.o_apb
	);

endmodule

// ==== hex_loader_tb.sv ====
// Testbench for the HEX program loader, driven by commands read from the stimulus file.

module hex_loader_tb import apb_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 16;
	localparam logic [11:0] stat_addr = 12'hfff;

	logic       clk;
	logic       soft_reset;
	logic       i_rx_valid;
	logic [7:0] i_rx_data;
	logic       o_rx_ready;
	apb_req_t   i_apb;
	apb_rsp_t   o_apb;

	integer seed = 53920;
	int     watch_cycles = 0;
	int     errors = 0;
	int     test_errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	string  test_name = "";
	string  lines[$];

	hex_loader_top hex_loader_top_inst (
		.clk,
		.soft_reset,
		.i_rx_valid,
		.i_rx_data,
		.o_rx_ready,
		.i_apb,
		.o_apb
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Cycle budget is known once the stimulus is loaded.
	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clk);
		$display("Timeout: stimulus did not finish within %0d cycles", watch_cycles);
		$display("Test failed");
		$finish;
	end

	// ********************
	// Helpers
	// ********************

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic apply_reset();
		soft_reset = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		soft_reset = 1'b0;
		check("o_rx_ready", o_rx_ready, 1'b1);
		check("pready", o_apb.pready, 1'b0);
		check("pslverr", o_apb.pslverr, 1'b0);
	endtask

	// Each character is held until a rising edge sees ready high.
	task automatic send_record(input string rec, input bit burst);
		int gap;
		for (int i = 0; i < rec.len(); i++) begin
			i_rx_valid = 1'b1;
			i_rx_data = rec[i];
			while (!o_rx_ready)
				@(negedge clk);
			@(negedge clk);
			i_rx_valid = 1'b0;
			gap = burst ? 0 : $unsigned($random(seed)) % 4;
			repeat (gap) @(negedge clk);
		end
	endtask

	task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [7:0] wdata,
			output logic [7:0] rdata, output logic err);
		i_apb.psel = 1'b1;
		i_apb.penable = 1'b0;
		i_apb.pwrite = wr;
		i_apb.paddr = addr;
		i_apb.pwdata = wdata;
		@(negedge clk);
		i_apb.penable = 1'b1;	// Access phase.
		#1;
		check("pready", o_apb.pready, 1'b1);
		rdata = o_apb.prdata;
		err = o_apb.pslverr;
		@(negedge clk);
		i_apb.psel = 1'b0;
		i_apb.penable = 1'b0;
	endtask

	// Polls until the status reads the expected word twice in a row.
	// The end entry of a record that just finished may still be on its way.
	task automatic wait_status(input logic [7:0] exp);
		logic [7:0] rdata;
		logic [7:0] prev;
		logic       err;
		int         polls;
		polls = 0;
		rdata = 'x;
		do begin
			prev = rdata;
			apb_access(1'b0, stat_addr, 8'h00, rdata, err);
			polls++;
		end while ((rdata !== exp || prev !== rdata) && polls < 32);
		check("status", rdata, exp);
		check("pslverr", err, 1'b0);
	endtask

	task automatic close_test();
		if (test_name != "") begin
			tests_run++;
			if (test_errors == 0)
				$display("%s: ok", test_name);
			else begin
				tests_failed++;
				$display("%s: FAIL with %0d errors", test_name, test_errors);
			end
		end
	endtask

	// ********************
	// Command loop
	// ********************

	task automatic run_command(input string line);
		string       cmd;
		string       arg;
		logic [11:0] addr;
		logic [7:0]  val;
		logic [7:0]  rdata;
		logic        err;
		void'($sscanf(line, "%s", cmd));
		case (cmd)
		"N": begin
			void'($sscanf(line, "%s %s", cmd, arg));
			close_test();
			test_name = arg;
			test_errors = 0;
			apply_reset();
		end
		"C", "B": begin
			void'($sscanf(line, "%s %s", cmd, arg));
			send_record(arg, cmd == "B");
		end
		"R": begin
			void'($sscanf(line, "%s %h %h", cmd, addr, val));
			apb_access(1'b0, addr, 8'h00, rdata, err);
			check($sformatf("prdata[%03h]", addr), rdata, val);
			check("pslverr", err, 1'b0);
		end
		"E": begin
			void'($sscanf(line, "%s %h", cmd, addr));
			apb_access(1'b0, addr, 8'h00, rdata, err);
			check("pslverr", err, 1'b1);
		end
		"W": begin
			void'($sscanf(line, "%s %h %h", cmd, addr, val));
			apb_access(1'b1, addr, val, rdata, err);
			check("pslverr", err, 1'b1);
		end
		"S": begin
			void'($sscanf(line, "%s %h", cmd, val));
			wait_status(val);
		end
		default: begin
			$display("Stimulus line not understood: %s", line);
			errors++;
			test_errors++;
		end
		endcase
	endtask

	initial begin
		int    fd;
		int    chars;
		string line;
		string cmd;
		string rec;

		soft_reset = 1'b1;
		i_rx_valid = 1'b0;
		i_rx_data = 8'h00;
		i_apb = '0;
		chars = 0;

		fd = $fopen("hex_loader_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Stimulus file hex_loader_stimulus.txt could not be opened");
			$display("Test failed");
			$finish;
		end
		else begin
			while ($fgets(line, fd)) begin
				if ($sscanf(line, "%s", cmd) == 1 && cmd[0] != "#") begin
					lines.push_back(line);
					if ((cmd == "C" || cmd == "B") && $sscanf(line, "%s %s", cmd, rec) == 2)
						chars += rec.len();
				end
			end
			$fclose(fd);
			watch_cycles = 20 * chars + 10 * lines.size();

			@(negedge clk);
			foreach (lines[i])
				run_command(lines[i]);
			close_test();

			$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
			if (errors == 0)
				$display("Test completed successfully");
			else
				$display("Test failed");
			$finish;
		end
	end

endmodule

// ==== hex_loader_stimulus.txt ====
# Columns: N name = reset, new test | C rec = send with gaps | B rec = send back to back
# R addr data = APB read | E addr = expect pslverr | W addr data = write | S status
N data_records
C :0300100011223387
C :04002000A5B6C7D8E2
S 40
R 010 11
R 011 22
R 012 33
R 020 A5
R 023 D8
N eof_done
C :0200400055AABF
C :00000001FF
S C0
R 040 55
R 041 AA
N bad_checksum
C :02005000123400
C :00000001FF
S 43
R 050 12
R 051 34
N bad_type
C :020000040000FA
C :010060007728
C :00000001FF
S 44
N clean_reload
C :010060007728
C :00000001FF
S C0
R 060 77
N bad_digit
C :01007000G1FF
C :010070009AF5
C :00000001FF
S 42
R 070 9A
N apb_errors
W 010 5A
E 400
E 800
E FFE
C :010000003CC3
C :01040000EE0D
S 45
R 000 3C
N burst
B :10010000000102030405060708090A0B0C0D0E0F77
B :10011000F0F1F2F3F4F5F6F7F8F9FAFBFCFDFEFF67
B :00000001FF
S C0
R 100 00
R 108 08
R 10F 0F
R 110 F0
R 11F FF

// ==== vlog.f ====
+incdir+.
ihex_pkg.sv
apb_pkg.sv
intel_hex_parser.sv
load_fifo.sv
load_memory.sv
hex_loader_top.sv
hex_loader_tb.sv

// ==== Bender.yml ====
package:
  name: hex_loader

sources:
  - include_dirs:
      - .
    files:
      - ihex_pkg.sv
      - apb_pkg.sv
      - intel_hex_parser.sv
      - load_fifo.sv
      - load_memory.sv
      - hex_loader_top.sv
  - target: simulation
    files:
      - hex_loader_tb.sv
